// File: rtl/convEnginePkg.sv
package convEnginePkg;

	localparam int PixelBits  = 8;
	localparam int RowPixels  = 8;
	localparam int Lanes      = 4;
	localparam int KernelSize = 3;
	localparam int SumBits    = 20;

	typedef logic [PixelBits-1:0] pixel_t;

	// Pixel 0 sits in the low byte
	typedef struct packed {
		pixel_t [RowPixels-1:0] px;
	} row_t;

	typedef struct packed {
		row_t top;
		row_t middle;
		row_t bottom;
	} window_t;

	typedef logic signed [15:0] coef_t;

	// Row major, entry 0 is the top-left tap
	typedef coef_t [KernelSize*KernelSize-1:0] kernel_t;

	// Sharpen, listed from entry 8 down to entry 0
	localparam kernel_t DefaultKernel = {
		-16'sd1, -16'sd1, -16'sd1,
		-16'sd1,  16'sd9, -16'sd1,
		-16'sd1, -16'sd1, -16'sd1
	};

	typedef logic signed [SumBits-1:0] sum_t;
	typedef sum_t [Lanes-1:0][KernelSize-1:0] rowSums_t;

	typedef logic [15:0] dim_t;
	typedef logic [31:0] addr_t;

	typedef struct packed {
		pixel_t [Lanes-1:0] lane;
	} outWord_t;

	typedef struct packed {
		logic valid;
		logic last;
	} tag_t;

endpackage

// File: rtl/convCtrl.sv
module convCtrl import convEnginePkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  dim_t  i_width,
	input  dim_t  i_height,
	input  logic  i_rowValid,
	output logic  o_rowReq,
	output addr_t o_rdAddress,
	output logic  o_shift,
	output tag_t  o_tag
);

	typedef enum logic [1:0] {
		stateInit,
		stateReq,
		stateWait,
		stateIdle
	} state_t;

	state_t state;

	// Image size, captured once after reset
	dim_t widthReg;
	dim_t heightReg;

	dim_t  stripeCnt;
	dim_t  rowCnt;
	addr_t rowAddr;
	addr_t stripeAddr;

	dim_t  lastStripe;
	dim_t  lastRow;
	addr_t stride;
	logic  isLastStripe;
	logic  isLastRow;

	// Padded image has two extra columns and two extra rows
	assign stride       = addr_t'(widthReg) + addr_t'(KernelSize - 1);
	assign lastStripe   = dim_t'(widthReg / Lanes - 1);
	assign lastRow      = heightReg + dim_t'(KernelSize - 2);
	assign isLastStripe = (stripeCnt == lastStripe);
	assign isLastRow    = (rowCnt == lastRow);

	assign o_rowReq    = (state == stateReq);
	assign o_rdAddress = rowAddr;

	// Row enters the window in the same cycle it arrives
	assign o_shift = (state == stateWait) && i_rowValid;

	always_ff @(posedge clk) begin
		if (state == stateInit) begin
			widthReg  <= i_width;
			heightReg <= i_height;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= stateInit;
			stripeCnt  <= '0;
			rowCnt     <= '0;
			rowAddr    <= '0;
			stripeAddr <= '0;
		end else begin
			case (state)
				stateInit: begin
					stripeCnt  <= '0;
					rowCnt     <= '0;
					rowAddr    <= '0;
					stripeAddr <= '0;
					state      <= stateReq;
				end
				stateReq: begin
					// Request lasts a single cycle
					state <= stateWait;
				end
				stateWait: begin
					if (i_rowValid) begin
						if (isLastRow) begin
							// Move to the top of the next stripe
							rowCnt     <= '0;
							stripeCnt  <= stripeCnt + dim_t'(1);
							stripeAddr <= stripeAddr + addr_t'(Lanes);
							rowAddr    <= stripeAddr + addr_t'(Lanes);
							state      <= isLastStripe ? stateIdle : stateReq;
						end else begin
							rowCnt  <= rowCnt + dim_t'(1);
							rowAddr <= rowAddr + stride;
							state   <= stateReq;
						end
					end
				end
				stateIdle: begin
					// Image finished, wait for reset
					state <= stateIdle;
				end
				default: begin
					state <= stateInit;
				end
			endcase
		end
	end

	// Tag travels with the window just loaded
	always_ff @(posedge clk) begin
		if (reset) begin
			o_tag <= '0;
		end else begin
			o_tag.valid <= o_shift && (rowCnt >= dim_t'(KernelSize - 1));
			o_tag.last  <= o_shift && isLastRow && isLastStripe;
		end
	end

endmodule

// File: rtl/rowWindow.sv
module rowWindow import convEnginePkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    i_shift,
	input  row_t    i_rowData,
	output window_t o_window
);

	window_t window;

	// New row at the bottom, oldest row drops off the top
	always_ff @(posedge clk) begin
		if (reset) begin
			window <= '0;
		end else if (i_shift) begin
			window.top    <= window.middle;
			window.middle <= window.bottom;
			window.bottom <= i_rowData;
		end
	end

	assign o_window = window;

endmodule

// File: rtl/macArray.sv
module macArray import convEnginePkg::*; #(
	parameter kernel_t Kernel = DefaultKernel
) (
	input  logic     clk,
	input  logic     reset,
	input  window_t  i_window,
	input  tag_t     i_tag,
	output rowSums_t o_rowSums,
	output tag_t     o_tag
);

	row_t rows [KernelSize];

	// One product per lane, kernel row and kernel column
	sum_t products [Lanes][KernelSize][KernelSize];
	tag_t productTag;

	assign rows[0] = i_window.top;
	assign rows[1] = i_window.middle;
	assign rows[2] = i_window.bottom;

	// Stage 1, lane j uses pixels j to j+2 of each row
	always_ff @(posedge clk) begin
		for (int l = 0; l < Lanes; l++) begin
			for (int a = 0; a < KernelSize; a++) begin
				for (int b = 0; b < KernelSize; b++) begin
					products[l][a][b] <= $signed({1'b0, rows[a].px[l + b]}) *
						$signed(Kernel[a * KernelSize + b]);
				end
			end
		end
	end

	// Stage 2, one partial sum per kernel row
	always_ff @(posedge clk) begin
		for (int l = 0; l < Lanes; l++) begin
			for (int a = 0; a < KernelSize; a++) begin
				o_rowSums[l][a] <= products[l][a][0] + products[l][a][1] +
					products[l][a][2];
			end
		end
	end

	// Tag follows the same two stages
	always_ff @(posedge clk) begin
		if (reset) begin
			productTag <= '0;
			o_tag      <= '0;
		end else begin
			productTag <= i_tag;
			o_tag      <= productTag;
		end
	end

endmodule

// File: rtl/reduceClamp.sv
module reduceClamp import convEnginePkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  rowSums_t i_rowSums,
	input  tag_t     i_tag,
	output outWord_t o_data,
	output logic     o_valid,
	output logic     o_done
);

	// Two guard bits for adding three row sums
	localparam int TotalBits = SumBits + 2;

	logic signed [TotalBits-1:0] totals [Lanes];
	pixel_t clamped [Lanes];
	tag_t   totalTag;

	always_ff @(posedge clk) begin
		for (int l = 0; l < Lanes; l++) begin
			totals[l] <= $signed(i_rowSums[l][0]) + $signed(i_rowSums[l][1]) +
				$signed(i_rowSums[l][2]);
		end
	end

	// Saturate to the pixel range
	always_comb begin
		for (int l = 0; l < Lanes; l++) begin
			if (totals[l] > 255) begin
				clamped[l] = '1;
			end else if (totals[l] < 0) begin
				clamped[l] = '0;
			end else begin
				clamped[l] = totals[l][PixelBits-1:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int l = 0; l < Lanes; l++) begin
			o_data.lane[l] <= clamped[l];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			totalTag <= '0;
			o_valid  <= 1'b0;
			o_done   <= 1'b0;
		end else begin
			totalTag <= i_tag;
			o_valid  <= totalTag.valid;
			o_done   <= totalTag.valid && totalTag.last;
		end
	end

endmodule

// File: rtl/convEngine.sv
module convEngine import convEnginePkg::*; #(
	parameter kernel_t Kernel = DefaultKernel
) (
	input  logic     clk,
	input  logic     reset,
	input  dim_t     i_width,
	input  dim_t     i_height,
	input  row_t     i_rowData,
	input  logic     i_rowValid,
	output logic     o_rowReq,
	output addr_t    o_rdAddress,
	output outWord_t o_data,
	output logic     o_valid,
	output logic     o_done
);

	logic     shift;
	tag_t     windowTag;
	window_t  window;
	rowSums_t rowSums;
	tag_t     sumTag;

	convCtrl u_ctrl (
		.clk        (clk),
		.reset      (reset),
		.i_width    (i_width),
		.i_height   (i_height),
		.i_rowValid (i_rowValid),
		.o_rowReq   (o_rowReq),
		.o_rdAddress(o_rdAddress),
		.o_shift    (shift),
		.o_tag      (windowTag)
	);

	rowWindow u_window (
		.clk      (clk),
		.reset    (reset),
		.i_shift  (shift),
		.i_rowData(i_rowData),
		.o_window (window)
	);

	// Kernel is only needed by the multipliers
	macArray #(
		.Kernel(Kernel)
	) u_mac (
		.clk      (clk),
		.reset    (reset),
		.i_window (window),
		.i_tag    (windowTag),
		.o_rowSums(rowSums),
		.o_tag    (sumTag)
	);

	reduceClamp u_reduce (
		.clk      (clk),
		.reset    (reset),
		.i_rowSums(rowSums),
		.i_tag    (sumTag),
		.o_data   (o_data),
		.o_valid  (o_valid),
		.o_done   (o_done)
	);

endmodule

// File: verification/tbClock.sv
module tbClock #(
	parameter int HalfPeriod  = 20,
	parameter int ResetCycles = 2
) (
	input  logic i_restart,
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #HalfPeriod clk = ~clk;
	end

	// Held for a fixed number of rising edges, rearmed by a restart pulse
	initial begin
		reset = 1'b1;
		forever begin
			repeat (ResetCycles) @(posedge clk);
			#2;
			reset = 1'b0;
			@(posedge i_restart);
			reset = 1'b1;
		end
	end

endmodule

// File: verification/convEngineTb.sv
module convEngineTb import convEnginePkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MemWords     = 256;
	localparam int RunTimeout   = 4000;
	localparam int IdleCycles   = 20;
	localparam int Latency      = 5;
	localparam int ImageFlat    = 0;
	localparam int ImageRandom  = 1;
	localparam int ImageChecker = 2;
	// Sharpen taps, row major from the top-left
	localparam int Sharpen [9] = '{-1, -1, -1, -1, 9, -1, -1, -1, -1};

	logic     clk;
	logic     reset;
	logic     restart = 1'b0;
	dim_t     width;
	dim_t     height;
	row_t     rowData;
	logic     rowValid;
	logic     rowReq;
	addr_t    rdAddress;
	outWord_t outData;
	logic     outValid;
	logic     outDone;

	logic [7:0]  mem [MemWords];
	logic [7:0]  savedImage [MemWords];
	logic [31:0] expectedWords [$];
	logic [31:0] receivedWords [$];
	logic [31:0] savedWords [$];
	int          completeCycles [$];
	addr_t       reqAddrs [$];

	int imgWidth    = 4;
	int imgHeight   = 1;
	int fixedDelay  = 1;
	bit randomDelay = 1'b0;
	int rowsSeen    = 0;
	int wordCount   = 0;
	int doneCount   = 0;
	int cycleCount  = 0;
	int valueErrors = 0;
	int otherErrors = 0;

	tbClock #(.HalfPeriod(20), .ResetCycles(2)) u_clock (
		.i_restart(restart),
		.clk      (clk),
		.reset    (reset)
	);

	convEngine u_dut (
		.clk        (clk),
		.reset      (reset),
		.i_width    (width),
		.i_height   (height),
		.i_rowData  (rowData),
		.i_rowValid (rowValid),
		.o_rowReq   (rowReq),
		.o_rdAddress(rdAddress),
		.o_data     (outData),
		.o_valid    (outValid),
		.o_done     (outDone)
	);

	task automatic checkValue(string name, logic [63:0] actual, logic [63:0] expected);
		if (actual !== expected) begin
			valueErrors++;
			$display("Error: %s is %h, expected %h at %0t ns", name, actual, expected, $time);
		end
	endtask

	task automatic reportFailure(string what);
		otherErrors++;
		$display("Failure at %0t ns: %s", $time, what);
	endtask

	// Answers each request with eight pixels after a fixed or random delay
	always begin : memoryModel
		addr_t reqAddr;
		int    delay;
		@(negedge clk);
		if (!reset && rowReq) begin
			reqAddr = rdAddress;
			reqAddrs.push_back(reqAddr);
			delay = randomDelay ? int'($urandom_range(6, 1)) : fixedDelay;
			repeat (delay) @(posedge clk);
			#2;
			for (int k = 0; k < RowPixels; k++) begin
				rowData.px[k] = mem[(int'(reqAddr) + k) % MemWords];
			end
			rowValid = 1'b1;
			@(posedge clk);
			#2;
			rowValid = 1'b0;
		end
	end

	// Output words in stripe-then-row order, each 5 cycles after its completing row
	always @(negedge clk) begin : collector
		logic [31:0] expWord;
		int          issueCycle;
		cycleCount++;
		if (!reset) begin
			if (rowValid) begin
				if (rowsSeen % (imgHeight + 2) >= 2) begin
					completeCycles.push_back(cycleCount);
				end
				rowsSeen++;
			end
			if (outValid) begin
				wordCount++;
				receivedWords.push_back(outData);
				if (outDone) begin
					doneCount++;
				end
				if (expectedWords.size() == 0) begin
					reportFailure("an output word appeared when none was expected");
				end else begin
					expWord = expectedWords.pop_front();
					checkValue("o_data", outData, expWord);
					checkValue("o_done", outDone, expectedWords.size() == 0);
				end
				if (completeCycles.size() == 0) begin
					reportFailure("an output word appeared without a completing row");
				end else begin
					issueCycle = completeCycles.pop_front();
					checkValue("o_valid latency", cycleCount - issueCycle, Latency);
				end
			end else if (outDone) begin
				reportFailure("o_done was high without o_valid");
			end
		end
	end

	// Padded image, any bytes past it get an address-unique filler
	task automatic loadImage(int w, int h, int kind);
		int stride;
		int index;
		stride = w + 2;
		for (int i = 0; i < MemWords; i++) begin
			mem[i] = 8'(i * 37 + 11);
		end
		for (int r = 0; r < h + 2; r++) begin
			for (int c = 0; c < stride; c++) begin
				index = r * stride + c;
				if (kind == ImageFlat) begin
					mem[index] = 8'd100;
				end else if (r == 0 || r == h + 1 || c == 0 || c == stride - 1) begin
					mem[index] = 8'd0;
				end else if (kind == ImageRandom) begin
					mem[index] = 8'($urandom);
				end else begin
					mem[index] = ((r + c) % 2 == 0) ? 8'hff : 8'h00;
				end
			end
		end
	endtask

	function automatic logic [31:0] expectedWord(int stripe, int outRow);
		logic [31:0] word;
		int          sum;
		int          col;
		word = '0;
		for (int j = 0; j < 4; j++) begin
			sum = 0;
			for (int a = 0; a < 3; a++) begin
				for (int b = 0; b < 3; b++) begin
					col = 4 * stripe + j + b;
					sum += Sharpen[a * 3 + b] * int'(mem[(outRow + a) * (imgWidth + 2) + col]);
				end
			end
			if (sum > 255) begin
				word[8 * j +: 8] = 8'hff;
			end else if (sum < 0) begin
				word[8 * j +: 8] = 8'h00;
			end else begin
				word[8 * j +: 8] = 8'(sum);
			end
		end
		return word;
	endfunction

	task automatic waitResetRelease();
		int waited;
		waited = 0;
		while (reset && waited < 10) begin
			@(posedge clk);
			#3;
			waited++;
		end
		if (reset) begin
			reportFailure("reset never went low");
		end
	endtask

	task automatic resetDut();
		@(posedge clk);
		#2;
		restart = 1'b1;
		@(posedge clk);
		#2;
		restart = 1'b0;
		waitResetRelease();
	endtask

	task automatic startRun(int w, int h, int delay, bit randomMode);
		imgWidth    = w;
		imgHeight   = h;
		fixedDelay  = delay;
		randomDelay = randomMode;
		@(posedge clk);
		#2;
		width  = dim_t'(w);
		height = dim_t'(h);
		resetDut();
		// Rows and requests from before the reset belong to no run
		expectedWords.delete();
		receivedWords.delete();
		completeCycles.delete();
		reqAddrs.delete();
		rowsSeen  = 0;
		wordCount = 0;
		doneCount = 0;
		for (int s = 0; s < w / 4; s++) begin
			for (int y = 0; y < h; y++) begin
				expectedWords.push_back(expectedWord(s, y));
			end
		end
	endtask

	// Wait for done, then the engine must stay quiet
	task automatic finishRun();
		int waited;
		waited = 0;
		while (doneCount == 0 && waited < RunTimeout) begin
			@(negedge clk);
			waited++;
		end
		if (doneCount == 0) begin
			reportFailure("o_done never went high");
		end
		for (int i = 0; i < IdleCycles; i++) begin
			@(negedge clk);
			checkValue("o_rowReq", rowReq, 0);
			checkValue("o_valid", outValid, 0);
		end
		checkValue("words left over", expectedWords.size(), 0);
	endtask

	task automatic verifyResetState();
		int waited;
		bit seen;
		loadImage(8, 2, ImageRandom);
		startRun(8, 2, 1, 1'b0);
		@(negedge clk);
		checkValue("o_valid", outValid, 0);
		checkValue("o_done", outDone, 0);
		checkValue("o_rowReq", rowReq, 0);
		waited = 1;
		seen = rowReq;
		while (!seen && waited < 2) begin
			@(negedge clk);
			waited++;
			seen = rowReq;
		end
		if (!seen) begin
			reportFailure("first row request came later than 2 cycles after reset");
		end
		finishRun();
		if (reqAddrs.size() < 2) begin
			reportFailure("fewer than two row requests were seen");
		end else begin
			checkValue("first o_rdAddress", reqAddrs[0], 0);
			checkValue("second o_rdAddress", reqAddrs[1], 8 + 2);
		end
	endtask

	task automatic runFlatImage();
		loadImage(8, 4, ImageFlat);
		startRun(8, 4, 1, 1'b0);
		finishRun();
		checkValue("word count", wordCount, 8);
		foreach (receivedWords[i]) begin
			checkValue("o_data", receivedWords[i], 32'h64646464);
		end
	endtask

	task automatic compareRandomImage();
		loadImage(12, 5, ImageRandom);
		savedImage = mem;
		startRun(12, 5, 1, 1'b0);
		finishRun();
		checkValue("word count", wordCount, 15);
		savedWords = receivedWords;
	endtask

	task automatic exerciseClamping();
		int highLanes;
		int lowLanes;
		highLanes = 0;
		lowLanes  = 0;
		loadImage(8, 4, ImageChecker);
		startRun(8, 4, 2, 1'b0);
		finishRun();
		foreach (receivedWords[i]) begin
			for (int j = 0; j < 4; j++) begin
				if (receivedWords[i][8 * j +: 8] == 8'hff) highLanes++;
				if (receivedWords[i][8 * j +: 8] == 8'h00) lowLanes++;
			end
		end
		if (highLanes == 0 || lowLanes == 0) begin
			reportFailure("checkerboard did not saturate lanes at both ends");
		end
	endtask

	task automatic repeatWithStalls();
		mem = savedImage;
		startRun(12, 5, 1, 1'b1);
		finishRun();
		checkValue("word count", receivedWords.size(), savedWords.size());
		if (receivedWords.size() == savedWords.size()) begin
			foreach (receivedWords[i]) begin
				checkValue("stalled o_data", receivedWords[i], savedWords[i]);
			end
		end
	endtask

	task automatic confirmDoneIdle();
		loadImage(4, 3, ImageRandom);
		startRun(4, 3, 3, 1'b0);
		finishRun();
		checkValue("o_done count", doneCount, 1);
		checkValue("word count", wordCount, 3);
	endtask

	initial begin : main
		width    = '0;
		height   = '0;
		rowData  = '0;
		rowValid = 1'b0;
		void'($urandom(32'heeafe57b));
		waitResetRelease();
		verifyResetState();
		runFlatImage();
		compareRandomImage();
		exerciseClamping();
		repeatWithStalls();
		confirmDoneIdle();
		$display("Value errors: %0d, other failures: %0d", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: convEngine.f
rtl/convEnginePkg.sv
rtl/convCtrl.sv
rtl/rowWindow.sv
rtl/macArray.sv
rtl/reduceClamp.sv
rtl/convEngine.sv
verification/tbClock.sv
verification/convEngineTb.sv

// File: run.sh
#!/bin/sh
# Build and run the convolution engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
	--timescale 1ns/100ps \
	-Wno-fatal \
	--top-module convEngineTb \
	-f convEngine.f \
	-o convEngineSim

output=$(./obj_dir/convEngineSim)
echo "$output"

if echo "$output" | grep -q "All tests passed"; then
	exit 0
fi
exit 1
